/* Makefile */
SHELL := /bin/bash
TOP   := floor_request_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f floor_request_top.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	set -o pipefail; ./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* dv/floor_request_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "elevator_defs.svh"

module floor_request_tb
    import elevator_pkg::*;
();

    localparam int NUM_ROWS         = 8;
    localparam int MAX_EXP          = 3;
    localparam int RESET_CYCLES     = 16;
    localparam int OFFER_WAIT       = 100;
    localparam int IDLE_WATCH       = 20;
    localparam int CYCLES_PER_ENTRY = 200;
    localparam int STEP_CYCLES      = 4;

    logic        clock;
    logic        reset_n;
    floor_mask_t hall_buttons;
    floor_mask_t car_buttons;
    logic        power_switch;
    logic        emergency_button;
    car_status_t car_status;
    logic        dispatch_ready;
    logic        dispatch_valid;
    dispatch_t   dispatch;
    floor_mask_t hall_lights;
    floor_mask_t car_lights;

    // Stimulus table, one entry per test
    string       row_name  [NUM_ROWS];
    floor_mask_t row_hall  [NUM_ROWS];
    floor_mask_t row_car   [NUM_ROWS];
    logic        row_power [NUM_ROWS];
    logic        row_emerg [NUM_ROWS];
    int          row_delay [NUM_ROWS];
    int          row_count [NUM_ROWS];
    floor_t      row_exp   [NUM_ROWS][MAX_EXP];
    int          row_fill;
    logic        table_loaded = 1'b0;

    int          value_errors;
    int          protocol_errors;

    floor_request_top uut (
        .clock            (clock),
        .reset_n          (reset_n),
        .hall_buttons     (hall_buttons),
        .car_buttons      (car_buttons),
        .power_switch     (power_switch),
        .emergency_button (emergency_button),
        .car_status       (car_status),
        .dispatch_ready   (dispatch_ready),
        .dispatch_valid   (dispatch_valid),
        .dispatch         (dispatch),
        .hall_lights      (hall_lights),
        .car_lights       (car_lights)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Table construction
    ////////////////////////////////////////////////////////////////////////////

    function automatic floor_mask_t floor_bit(input int f);
        return floor_mask_t'(1) << f;
    endfunction

    task automatic add_row(input string name, input floor_mask_t hall, input floor_mask_t car,
                           input logic power, input logic emerg, input int delay,
                           input int count, input int e0, input int e1, input int e2);
        row_name[row_fill]   = name;
        row_hall[row_fill]   = hall;
        row_car[row_fill]    = car;
        row_power[row_fill]  = power;
        row_emerg[row_fill]  = emerg;
        row_delay[row_fill]  = delay;
        row_count[row_fill]  = count;
        row_exp[row_fill][0] = floor_t'(e0);
        row_exp[row_fill][1] = floor_t'(e1);
        row_exp[row_fill][2] = floor_t'(e2);
        row_fill++;
    endtask

    // Expected floors follow the sweep rule, starting with the car at floor 0 going up
    task automatic load_table();
        row_fill = 0;
        add_row("sweep_up", floor_bit(3) | floor_bit(7), floor_bit(1),
                1'b1, 1'b0, 0, 3, 1, 3, 7);
        add_row("reverse", '0, floor_bit(2), 1'b1, 1'b0, 0, 1, 2, 0, 0);
        add_row("backpressure", floor_bit(5), '0, 1'b1, 1'b0, 10, 1, 5, 0, 0);
        add_row("press_at_car", floor_bit(5), floor_bit(5), 1'b1, 1'b0, 0, 0, 0, 0, 0);
        add_row("emergency", floor_bit(9), floor_bit(3), 1'b1, 1'b1, 0, 0, 0, 0, 0);
        add_row("power_off", floor_bit(1), floor_bit(0), 1'b0, 1'b0, 0, 0, 0, 0, 0);
        // Floors 9 and 3 stay pending from the emergency row
        add_row("resume", floor_bit(9), floor_bit(0), 1'b1, 1'b0, 0, 3, 9, 3, 0);
        add_row("long_sweep", floor_bit(4) | floor_bit(10), floor_bit(6),
                1'b1, 1'b0, 3, 3, 4, 6, 10);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and car model
    ////////////////////////////////////////////////////////////////////////////

    // Press for one cycle, then check the latched lights
    task automatic apply_press(input int r);
        floor_mask_t at_car;
        floor_mask_t exp_hall;
        floor_mask_t exp_car;
        at_car   = floor_bit(int'(car_status.floor));
        exp_hall = hall_lights;
        exp_car  = car_lights;
        if (row_power[r] && !row_emerg[r]) begin
            exp_hall = exp_hall | (row_hall[r] & ~at_car);
            exp_car  = exp_car | (row_car[r] & ~at_car);
        end
        power_switch     = row_power[r];
        emergency_button = row_emerg[r];
        hall_buttons     = row_hall[r];
        car_buttons      = row_car[r];
        @(negedge clock);
        hall_buttons = '0;
        car_buttons  = '0;
        assert (hall_lights == exp_hall) else begin
            $display("[ERROR] %s: hall_lights expected %h actual %h",
                     row_name[r], exp_hall, hall_lights);
            value_errors++;
        end
        assert (car_lights == exp_car) else begin
            $display("[ERROR] %s: car_lights expected %h actual %h",
                     row_name[r], exp_car, car_lights);
            value_errors++;
        end
    endtask

    task automatic observe_idle(input string name);
        int   cycles;
        logic offered;
        cycles  = 0;
        offered = 1'b0;
        while (cycles < IDLE_WATCH && !offered) begin
            @(negedge clock);
            cycles++;
            offered = dispatch_valid;
            assert (!offered) else begin
                $display("%s: a dispatch offer was raised although none was expected", name);
                protocol_errors++;
            end
        end
    endtask

    // Latch the presses while the emergency is briefly released, then raise it
    // again before the selector can offer, so pending lights meet a blocked selector
    task automatic latch_then_block(input int r);
        floor_mask_t at_car;
        floor_mask_t exp_hall;
        floor_mask_t exp_car;
        at_car   = floor_bit(int'(car_status.floor));
        exp_hall = hall_lights | (row_hall[r] & ~at_car);
        exp_car  = car_lights | (row_car[r] & ~at_car);
        power_switch     = 1'b1;
        emergency_button = 1'b0;
        hall_buttons     = row_hall[r];
        car_buttons      = row_car[r];
        @(negedge clock);
        hall_buttons     = '0;
        car_buttons      = '0;
        power_switch     = row_power[r];
        emergency_button = 1'b1;
        assert (hall_lights == exp_hall && car_lights == exp_car) else begin
            $display("[ERROR] %s: lights expected %h / %h actual %h / %h",
                     row_name[r], exp_hall, exp_car, hall_lights, car_lights);
            value_errors++;
        end
        observe_idle(row_name[r]);
    endtask

    // Travel one floor per STEP_CYCLES, then stop and check the served lights
    task automatic drive_car(input string name, input floor_t target);
        floor_mask_t served;
        floor_mask_t hall_before;
        floor_mask_t car_before;
        served = floor_bit(int'(target));
        car_status.moving = 1'b1;
        while (car_status.floor != target) begin
            repeat (STEP_CYCLES) @(negedge clock);
            if (target > car_status.floor) begin
                car_status.floor = car_status.floor + floor_t'(1);
            end
            else begin
                car_status.floor = car_status.floor - floor_t'(1);
            end
        end
        hall_before = hall_lights;
        car_before  = car_lights;
        car_status.moving = 1'b0;
        @(negedge clock);
        assert (hall_lights == (hall_before & ~served)) else begin
            $display("[ERROR] %s: hall_lights after arrival expected %h actual %h",
                     name, hall_before & ~served, hall_lights);
            value_errors++;
        end
        assert (car_lights == (car_before & ~served)) else begin
            $display("[ERROR] %s: car_lights after arrival expected %h actual %h",
                     name, car_before & ~served, car_lights);
            value_errors++;
        end
    endtask

    task automatic serve_offer(input string name, input floor_t exp_floor, input int ready_delay);
        int        waited;
        dir_e      exp_dir;
        dispatch_t held;
        waited = 0;
        while (!dispatch_valid && waited < OFFER_WAIT) begin
            @(negedge clock);
            waited++;
        end
        assert (dispatch_valid) else begin
            $display("%s: no dispatch offer for floor %0d within %0d cycles",
                     name, exp_floor, OFFER_WAIT);
            protocol_errors++;
        end
        if (dispatch_valid) begin
            exp_dir = (exp_floor > car_status.floor) ? DIR_UP : DIR_DOWN;
            assert (dispatch.floor == exp_floor) else begin
                $display("[ERROR] %s: dispatch floor expected %0d actual %0d",
                         name, exp_floor, dispatch.floor);
                value_errors++;
            end
            assert (dispatch.dir == exp_dir) else begin
                $display("[ERROR] %s: dispatch dir expected %0d actual %0d",
                         name, exp_dir, dispatch.dir);
                value_errors++;
            end
            held = dispatch;
            // Back-pressure, the offer must hold
            for (int k = 0; k < ready_delay; k++) begin
                @(negedge clock);
                assert (dispatch_valid) else begin
                    $display("%s: offer withdrawn while ready was low", name);
                    protocol_errors++;
                end
                assert (dispatch == held) else begin
                    $display("[ERROR] %s: held offer expected %h actual %h",
                             name, held, dispatch);
                    value_errors++;
                end
            end
            dispatch_ready = 1'b1;
            @(negedge clock);
            dispatch_ready = 1'b0;
            assert (!dispatch_valid) else begin
                $display("%s: offer still raised after the transfer", name);
                protocol_errors++;
            end
            drive_car(name, held.floor);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset_n          = 1'b0;
        hall_buttons     = '0;
        car_buttons      = '0;
        power_switch     = 1'b1;
        emergency_button = 1'b0;
        car_status       = '0;
        dispatch_ready   = 1'b0;
        value_errors     = 0;
        protocol_errors  = 0;
        load_table();
        table_loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        assert (!dispatch_valid) else begin
            $display("[ERROR] reset: dispatch_valid expected 0 actual %0b", dispatch_valid);
            value_errors++;
        end
        assert (hall_lights == '0 && car_lights == '0) else begin
            $display("[ERROR] reset: lights expected %h actual %h / %h",
                     floor_mask_t'(0), hall_lights, car_lights);
            value_errors++;
        end

        for (int r = 0; r < row_fill; r++) begin
            apply_press(r);
            if (row_count[r] == 0) begin
                observe_idle(row_name[r]);
            end
            if (row_emerg[r]) begin
                latch_then_block(r);
            end
            for (int e = 0; e < row_count[r]; e++) begin
                serve_offer(row_name[r], row_exp[r][e], row_delay[r]);
            end
            power_switch     = 1'b1;
            emergency_button = 1'b0;
        end

        @(negedge clock);
        $display("Check summary: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end
        else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int entries;
        wait (table_loaded);
        entries = 0;
        for (int r = 0; r < row_fill; r++) begin
            entries += row_count[r] + 1;
        end
        repeat (RESET_CYCLES + entries * CYCLES_PER_ENTRY) @(posedge clock);
        $display("Watchdog: the run did not finish within %0d cycles",
                 RESET_CYCLES + entries * CYCLES_PER_ENTRY);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* floor_request_top.f */
+incdir+include
src/elevator_pkg.sv
src/request_latch.sv
src/sweep_selector.sv
src/floor_request_top.sv
dv/floor_request_tb.sv

/* include/elevator_defs.svh */
`ifndef ELEVATOR_DEFS_SVH
`define ELEVATOR_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Building geometry
////////////////////////////////////////////////////////////////////////////

// Number of served floors, floor 0 is the lowest
`define NUM_FLOORS 11

// Bits needed to hold a floor number 0..NUM_FLOORS-1
`define FLOOR_W 4

////////////////////////////////////////////////////////////////////////////
// Derived values
////////////////////////////////////////////////////////////////////////////

// Highest floor number
`define TOP_FLOOR (`NUM_FLOORS - 1)

`endif

/* src/elevator_pkg.sv */
`default_nettype none

`include "elevator_defs.svh"

package elevator_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Floor encodings
    ////////////////////////////////////////////////////////////////////////////

    // Floor number, 0 = lowest floor
    typedef logic [`FLOOR_W-1:0] floor_t;

    // One bit per floor, bit i belongs to floor i
    typedef logic [`NUM_FLOORS-1:0] floor_mask_t;

    // Sweep direction
    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } dir_e;

    ////////////////////////////////////////////////////////////////////////////
    // Interfaces to the motion controller
    ////////////////////////////////////////////////////////////////////////////

    // Car position as reported by the motion controller
    typedef struct packed {
        floor_t floor;
        logic   moving;
    } car_status_t;

    // Target offered to the motion controller
    typedef struct packed {
        floor_t floor;
        dir_e   dir;      // travel direction seen from the car at offer time
    } dispatch_t;

    // Selector FSM
    typedef enum logic [1:0] {
        SEL_IDLE   = 2'd0,
        SEL_OFFER  = 2'd1,
        SEL_TRAVEL = 2'd2
    } sel_state_e;

endpackage

`default_nettype wire

/* src/floor_request_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "elevator_defs.svh"

module floor_request_top
    import elevator_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,

    // Button presses
    input  floor_mask_t hall_buttons,
    input  floor_mask_t car_buttons,

    input  logic        power_switch,
    input  logic        emergency_button,

    // Motion controller side
    input  car_status_t car_status,
    input  logic        dispatch_ready,
    output logic        dispatch_valid,
    output dispatch_t   dispatch,

    // Button lights
    output floor_mask_t hall_lights,
    output floor_mask_t car_lights
);

    ////////////////////////////////////////////////////////////////////////////
    // Request latches
    ////////////////////////////////////////////////////////////////////////////

    // Calls from the landings
    request_latch hall_latch (
        .clock            (clock),
        .reset_n          (reset_n),
        .buttons          (hall_buttons),
        .power_switch     (power_switch),
        .emergency_button (emergency_button),
        .car_status       (car_status),
        .lights           (hall_lights)
    );

    // Destinations from the car panel
    request_latch car_latch (
        .clock            (clock),
        .reset_n          (reset_n),
        .buttons          (car_buttons),
        .power_switch     (power_switch),
        .emergency_button (emergency_button),
        .car_status       (car_status),
        .lights           (car_lights)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Target selection
    ////////////////////////////////////////////////////////////////////////////

    sweep_selector selector (
        .clock            (clock),
        .reset_n          (reset_n),
        .hall_lights      (hall_lights),
        .car_lights       (car_lights),
        .car_status       (car_status),
        .power_switch     (power_switch),
        .emergency_button (emergency_button),
        .dispatch_ready   (dispatch_ready),
        .dispatch_valid   (dispatch_valid),
        .dispatch         (dispatch)
    );

endmodule

`default_nettype wire

/* src/request_latch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "elevator_defs.svh"

module request_latch
    import elevator_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,

    // Button presses, one bit per floor
    input  floor_mask_t buttons,

    input  logic        power_switch,
    input  logic        emergency_button,

    // Car position from the motion controller
    input  car_status_t car_status,

    // Request lights, one bit per floor
    output floor_mask_t lights
);

    ////////////////////////////////////////////////////////////////////////////
    // Arrival and press qualification
    ////////////////////////////////////////////////////////////////////////////

    // One-hot floor where the car currently stands still
    floor_mask_t at_floor;

    // Presses that are allowed to set a light
    floor_mask_t accepted;

    floor_mask_t lights_next;

    logic        accept_en;

    // New requests only with power on and no emergency
    assign accept_en = power_switch && !emergency_button;

    always_comb begin
        at_floor = '0;
        if (!car_status.moving) begin
            at_floor = floor_mask_t'(1) << car_status.floor;
        end
    end

    // A press at the floor where the car waits is already served
    assign accepted = accept_en ? (buttons & ~at_floor) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Light register
    ////////////////////////////////////////////////////////////////////////////

    // Clear beats set, lights hold otherwise
    always_comb begin
        lights_next = lights;
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (at_floor[i]) begin
                lights_next[i] = 1'b0;
            end
            else if (accepted[i]) begin
                lights_next[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end
        else begin
            lights <= lights_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Standing at a floor for one cycle serves both its request sources
    a_clear_on_arrival : assert property (
        @(posedge clock) disable iff (!reset_n)
        (at_floor != '0) |=> ((lights & $past(at_floor)) == '0)
    ) else $error("request_latch: light still set after car stood at its floor");

endmodule

`default_nettype wire

/* src/sweep_selector.sv */
`timescale 1ns/1ps
`default_nettype none

`include "elevator_defs.svh"

module sweep_selector
    import elevator_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,

    // Pending requests from both latches
    input  floor_mask_t hall_lights,
    input  floor_mask_t car_lights,

    input  car_status_t car_status,

    input  logic        power_switch,
    input  logic        emergency_button,

    // Offer to the motion controller
    input  logic        dispatch_ready,
    output logic        dispatch_valid,
    output dispatch_t   dispatch
);

    sel_state_e  state;
    dir_e        sweep_dir;

    floor_mask_t pending;
    floor_mask_t above_mask;
    floor_mask_t below_mask;

    floor_t      up_target;
    floor_t      down_target;
    logic        has_above;
    logic        has_below;
    logic        have_target;
    logic        go_up;
    logic        offer_ok;
    logic        at_target;

    dispatch_t   next_offer;

    ////////////////////////////////////////////////////////////////////////////
    // Pending set split around the car
    ////////////////////////////////////////////////////////////////////////////

    assign pending = hall_lights | car_lights;

    always_comb begin
        above_mask = '0;
        below_mask = '0;
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (floor_t'(i) > car_status.floor) begin
                above_mask[i] = pending[i];
            end
            if (floor_t'(i) < car_status.floor) begin
                below_mask[i] = pending[i];
            end
        end
    end

    assign has_above = |above_mask;
    assign has_below = |below_mask;

    // Nearest request above, scan from the top so the lowest one wins
    always_comb begin
        up_target = '0;
        for (int i = `NUM_FLOORS - 1; i >= 0; i--) begin
            if (above_mask[i]) begin
                up_target = floor_t'(i);
            end
        end
    end

    // Nearest request below, the last hit is the highest one
    always_comb begin
        down_target = '0;
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            if (below_mask[i]) begin
                down_target = floor_t'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Selection rule
    ////////////////////////////////////////////////////////////////////////////

    // Keep sweeping while work lies ahead, otherwise turn around
    assign go_up       = (sweep_dir == DIR_UP) ? has_above : !has_below;
    assign have_target = has_above || has_below;

    always_comb begin
        next_offer.floor = go_up ? up_target : down_target;
        next_offer.dir   = go_up ? DIR_UP : DIR_DOWN;
    end

    assign offer_ok = have_target && !car_status.moving &&
                      power_switch && !emergency_button;

    // Car parked at the accepted target
    assign at_target = !car_status.moving && (car_status.floor == dispatch.floor);

    ////////////////////////////////////////////////////////////////////////////
    // Selector FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state          <= SEL_IDLE;
            sweep_dir      <= DIR_UP;
            dispatch_valid <= 1'b0;
        end
        else begin
            case (state)
                SEL_IDLE: begin
                    if (offer_ok) begin
                        sweep_dir      <= next_offer.dir;
                        dispatch_valid <= 1'b1;
                        state          <= SEL_OFFER;
                    end
                end
                SEL_OFFER: begin
                    // Offer is held until taken, even through an emergency
                    if (dispatch_ready) begin
                        dispatch_valid <= 1'b0;
                        state          <= SEL_TRAVEL;
                    end
                end
                SEL_TRAVEL: begin
                    if (at_target) begin
                        state <= SEL_IDLE;
                    end
                end
                default: begin
                    dispatch_valid <= 1'b0;
                    state          <= SEL_IDLE;
                end
            endcase
        end
    end

    // Offer payload, loaded only when an offer is raised
    always_ff @(posedge clock) begin
        if (state == SEL_IDLE && offer_ok) begin
            dispatch <= next_offer;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_offer_stable : assert property (
        @(posedge clock) disable iff (!reset_n)
        (dispatch_valid && !dispatch_ready) |=> (dispatch_valid && $stable(dispatch))
    ) else $error("sweep_selector: offer changed under back-pressure");

    a_floor_range : assert property (
        @(posedge clock) disable iff (!reset_n)
        dispatch_valid |-> (dispatch.floor < `NUM_FLOORS)
    ) else $error("sweep_selector: dispatch floor out of range");

    a_no_valid_in_travel : assert property (
        @(posedge clock) disable iff (!reset_n)
        (state == SEL_TRAVEL) |-> !dispatch_valid
    ) else $error("sweep_selector: offer raised while travelling");

endmodule

`default_nettype wire
